//--- rtl/ctrl_defs.svh
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// Instruction field widths
`define CTRL_OP_W           6
`define CTRL_FUNCT_W        6

`define CTRL_OP_RTYPE       6'h00
`define CTRL_OP_J           6'h02
`define CTRL_OP_JAL         6'h03
`define CTRL_OP_BEQ         6'h04
`define CTRL_OP_BNE         6'h05
`define CTRL_OP_BLE         6'h06
`define CTRL_OP_BGT         6'h07
`define CTRL_OP_LB          6'h20
`define CTRL_OP_LH          6'h21
`define CTRL_OP_LW          6'h23
`define CTRL_OP_SB          6'h28
`define CTRL_OP_SH          6'h29
`define CTRL_OP_SW          6'h2b

`define CTRL_FUNCT_ADD      6'h20
`define CTRL_FUNCT_SUB      6'h22
`define CTRL_FUNCT_AND      6'h24

// Cycles spent in the multi-step states
`define CTRL_FETCH_STEPS    4
`define CTRL_DECODE_STEPS   2
`define CTRL_MEM_STEPS      4
`define CTRL_EXC_STEPS      4
`define CTRL_STEP_W         2

`define CTRL_LINK_REG       31      // Written by jal

`endif

//--- rtl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

        typedef enum logic [3:0] {
                ADD, SUB, AND,
                BEQ, BNE, BGT, BLE,
                LB, LH, LW,
                SB, SH, SW,
                J, JAL,
                ILLEGAL
        } instr_class_e;

        typedef enum logic [3:0] {
                FETCH, DECODE, ARITH, ARITH_WB, BRANCH, BRANCH_TAKEN,
                MEM_ADDR, LOAD_WB, STORE, JUMP, EXCEPTION
        } ctrl_state_e;

        typedef enum logic {
                ILLEGAL_OP,
                OVERFLOW
        } exc_cause_e;

        typedef struct packed {
                logic overflow;
                logic gt;
                logic eq;
        } alu_flags_t;

        typedef enum logic [1:0] {PC_ALU_OUT, PC_ALU, PC_JUMP, PC_LOAD} pc_src_e;
        typedef enum logic [1:0] {A_PC, A_A, A_B} alu_a_e;
        typedef enum logic [1:0] {B_B, B_FOUR, B_IMM, B_OFFSET} alu_b_e;
        typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_CMP} alu_op_e;
        typedef enum logic [2:0] {IORD_PC, IORD_ALU, IORD_VEC_OP, IORD_VEC_OVF} iord_e;
        typedef enum logic [1:0] {REG_RT, REG_RD, REG_LINK} bank_reg_e;
        typedef enum logic [1:0] {DATA_ALU_OUT, DATA_MEM, DATA_PC} bank_data_e;
        typedef enum logic [1:0] {SZ_WORD, SZ_HALF, SZ_BYTE} size_e;    // Load and store size

        typedef struct packed {
                pc_src_e    pc_src;
                alu_a_e     alu_src_a;
                alu_b_e     alu_src_b;
                alu_op_e    alu_op;
                iord_e      iord;
                bank_reg_e  bank_reg;
                bank_data_e bank_data;
                size_e      load_ctrl;
                size_e      store_ctrl;
        } mux_sel_t;

        typedef struct packed {
                logic mem_wr;
                logic ir_write;
                logic pc_write;
                logic bank_write;
                logic epc_write;
                logic a_write;
                logic b_write;
                logic alu_out_write;
                logic mem_reg_write;
        } write_en_t;

endpackage

`default_nettype wire

//--- rtl/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_defs.svh"

module instr_decoder
        import ctrl_pkg::*;
(
        input  wire logic [`CTRL_OP_W-1:0]    op,
        input  wire logic [`CTRL_FUNCT_W-1:0] funct,
        output instr_class_e                  dec_class
);

        always_comb begin
                case (op)
                        `CTRL_OP_RTYPE: begin
                                case (funct)
                                        `CTRL_FUNCT_ADD: dec_class = ADD;
                                        `CTRL_FUNCT_SUB: dec_class = SUB;
                                        `CTRL_FUNCT_AND: dec_class = AND;
                                        default:         dec_class = ILLEGAL;
                                endcase
                        end

                        // Branches
                        `CTRL_OP_BEQ: dec_class = BEQ;
                        `CTRL_OP_BNE: dec_class = BNE;
                        `CTRL_OP_BGT: dec_class = BGT;
                        `CTRL_OP_BLE: dec_class = BLE;

                        // Memory access
                        `CTRL_OP_LB:  dec_class = LB;
                        `CTRL_OP_LH:  dec_class = LH;
                        `CTRL_OP_LW:  dec_class = LW;
                        `CTRL_OP_SB:  dec_class = SB;
                        `CTRL_OP_SH:  dec_class = SH;
                        `CTRL_OP_SW:  dec_class = SW;

                        `CTRL_OP_J:   dec_class = J;
                        `CTRL_OP_JAL: dec_class = JAL;
                        default:      dec_class = ILLEGAL;  // Unknown opcode traps
                endcase
        end

endmodule

`default_nettype wire

//--- rtl/ctrl_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_defs.svh"

module ctrl_sequencer
        import ctrl_pkg::*;
(
        input  wire logic                     clk,
        input  wire logic                     reset,
        input  wire instr_class_e             dec_class,
        input  wire alu_flags_t               flags,
        output ctrl_state_e                   state,
        output logic [`CTRL_STEP_W-1:0]       step,
        output instr_class_e                  cur_class,
        output exc_cause_e                    cause
);

        ctrl_state_e next_state;
        logic [2:0]  steps;
        logic        last;

        function automatic logic [2:0] state_steps(ctrl_state_e s);
                case (s)
                        FETCH:     return 3'(`CTRL_FETCH_STEPS);
                        DECODE:    return 3'(`CTRL_DECODE_STEPS);
                        MEM_ADDR:  return 3'(`CTRL_MEM_STEPS);
                        EXCEPTION: return 3'(`CTRL_EXC_STEPS);
                        default:   return 3'd1;
                endcase
        endfunction

        // First state of the instruction's execute phase
        function automatic ctrl_state_e dispatch(instr_class_e c);
                case (c)
                        ADD, SUB, AND:          return ARITH;
                        BEQ, BNE, BGT, BLE:     return BRANCH;
                        LB, LH, LW, SB, SH, SW: return MEM_ADDR;
                        J, JAL:                 return JUMP;
                        default:                return EXCEPTION;
                endcase
        endfunction

        function automatic logic branch_taken(instr_class_e c, alu_flags_t f);
                case (c)
                        BEQ:     return f.eq;
                        BNE:     return !f.eq;
                        BGT:     return f.gt;
                        default: return !f.gt;  // ble
                endcase
        endfunction

        assign steps = state_steps(state);
        assign last  = ({1'b0, step} == steps - 3'd1);

        always_comb begin
                next_state = state;
                if (last) begin
                        case (state)
                                FETCH:  next_state = DECODE;
                                DECODE: next_state = dispatch(dec_class);
                                ARITH: begin
                                        // Overflow on and is ignored
                                        if ((cur_class == ADD || cur_class == SUB) &&
                                            flags.overflow)
                                                next_state = EXCEPTION;
                                        else
                                                next_state = ARITH_WB;
                                end
                                BRANCH: begin
                                        if (branch_taken(cur_class, flags))
                                                next_state = BRANCH_TAKEN;
                                        else
                                                next_state = FETCH;
                                end
                                MEM_ADDR: begin
                                        if (cur_class inside {LB, LH, LW})
                                                next_state = LOAD_WB;
                                        else
                                                next_state = STORE;
                                end
                                default: next_state = FETCH;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        state     <= FETCH;
                        step      <= '0;
                        cur_class <= ILLEGAL;
                        cause     <= ILLEGAL_OP;
                end else begin
                        state <= next_state;
                        step  <= last ? '0 : step + 1'b1;
                        if (state == DECODE && last)
                                cur_class <= dec_class;   // IR is stable by now
                        if (next_state == EXCEPTION && state != EXCEPTION)
                                cause <= (state == ARITH) ? OVERFLOW : ILLEGAL_OP;
                end
        end

        a_step_in_range: assert property (@(posedge clk) disable iff (reset)
                {1'b0, step} < steps);

        a_state_legal: assert property (@(posedge clk) disable iff (reset)
                !$isunknown(state) && state <= EXCEPTION);

endmodule

`default_nettype wire

//--- rtl/ctrl_outputs.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_defs.svh"

module ctrl_outputs
        import ctrl_pkg::*;
(
        input  wire logic                     clk,
        input  wire ctrl_state_e              state,
        input  wire logic [`CTRL_STEP_W-1:0]  step,
        input  wire instr_class_e             cur_class,
        input  wire exc_cause_e               cause,
        output mux_sel_t                      sel,
        output write_en_t                     wen
);

        function automatic alu_op_e class_alu_op(instr_class_e c);
                case (c)
                        SUB:     return ALU_SUB;
                        AND:     return ALU_AND;
                        default: return ALU_ADD;
                endcase
        endfunction

        function automatic size_e class_size(instr_class_e c);
                case (c)
                        LB, SB:  return SZ_BYTE;
                        LH, SH:  return SZ_HALF;
                        default: return SZ_WORD;
                endcase
        endfunction

        always_comb begin
                sel = '0;
                wen = '0;
                case (state)
                        FETCH: begin
                                sel.iord      = IORD_PC;
                                sel.alu_src_a = A_PC;
                                sel.alu_src_b = B_FOUR;     // PC + 4
                                sel.alu_op    = ALU_ADD;
                                sel.pc_src    = PC_ALU_OUT;
                                if (step == 2'(`CTRL_FETCH_STEPS - 1)) begin
                                        wen.ir_write = 1'b1;
                                        wen.pc_write = 1'b1;
                                end else begin
                                        wen.alu_out_write = 1'b1;
                                end
                        end
                        DECODE: begin
                                // Branch target computed early
                                if (step == 2'd0) begin
                                        sel.alu_src_a     = A_PC;
                                        sel.alu_src_b     = B_OFFSET;
                                        sel.alu_op        = ALU_ADD;
                                        wen.a_write       = 1'b1;
                                        wen.b_write       = 1'b1;
                                        wen.alu_out_write = 1'b1;
                                end
                        end
                        ARITH: begin
                                sel.alu_src_a     = A_A;
                                sel.alu_src_b     = B_B;
                                sel.alu_op        = class_alu_op(cur_class);
                                wen.alu_out_write = 1'b1;
                        end
                        ARITH_WB: begin
                                sel.bank_reg   = REG_RD;
                                sel.bank_data  = DATA_ALU_OUT;
                                wen.bank_write = 1'b1;
                        end
                        BRANCH: begin
                                sel.alu_src_a = A_A;
                                sel.alu_src_b = B_B;
                                sel.alu_op    = ALU_CMP;
                        end
                        BRANCH_TAKEN: begin
                                sel.pc_src   = PC_ALU_OUT;
                                wen.pc_write = 1'b1;
                        end
                        MEM_ADDR: begin
                                if (step == 2'd0) begin
                                        sel.alu_src_a     = A_A;
                                        sel.alu_src_b     = B_IMM;
                                        sel.alu_op        = ALU_ADD;
                                        wen.alu_out_write = 1'b1;
                                end else begin
                                        sel.iord          = IORD_ALU;
                                        wen.mem_reg_write = (step == 2'(`CTRL_MEM_STEPS - 1));
                                end
                        end
                        LOAD_WB: begin
                                sel.bank_reg   = REG_RT;
                                sel.bank_data  = DATA_MEM;
                                sel.load_ctrl  = class_size(cur_class);
                                wen.bank_write = 1'b1;
                        end
                        STORE: begin
                                sel.iord       = IORD_ALU;
                                sel.store_ctrl = class_size(cur_class);
                                wen.mem_wr     = 1'b1;
                        end
                        JUMP: begin
                                sel.pc_src   = PC_JUMP;
                                wen.pc_write = 1'b1;
                                if (cur_class == JAL) begin
                                        sel.bank_reg   = REG_LINK;
                                        sel.bank_data  = DATA_PC;
                                        wen.bank_write = 1'b1;
                                end
                        end
                        EXCEPTION: begin
                                sel.iord   = (cause == OVERFLOW) ? IORD_VEC_OVF : IORD_VEC_OP;
                                sel.pc_src = PC_LOAD;
                                if (step == 2'(`CTRL_EXC_STEPS - 1)) begin
                                        sel.load_ctrl = SZ_BYTE;    // Vector byte becomes new PC
                                        wen.pc_write  = 1'b1;
                                end else begin
                                        sel.alu_src_a     = A_PC;
                                        sel.alu_src_b     = B_FOUR;
                                        sel.alu_op        = ALU_SUB; // EPC gets PC - 4
                                        wen.epc_write     = 1'b1;
                                        wen.mem_reg_write = 1'b1;
                                end
                        end
                        default: ;
                endcase
        end

        a_no_mem_and_bank_write: assert property (@(posedge clk)
                !(wen.mem_wr && wen.bank_write));

        a_pc_write_states: assert property (@(posedge clk)
                wen.pc_write |-> state inside {FETCH, BRANCH_TAKEN, JUMP, EXCEPTION});

endmodule

`default_nettype wire

//--- rtl/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_defs.svh"

module control_unit
        import ctrl_pkg::*;
(
        input  wire logic                     clk,
        input  wire logic                     reset,
        input  wire logic [`CTRL_OP_W-1:0]    op,
        input  wire logic [`CTRL_FUNCT_W-1:0] funct,
        input  wire alu_flags_t               flags,
        output mux_sel_t                      sel,
        output write_en_t                     wen
);

        instr_class_e                 dec_class;
        instr_class_e                 cur_class;
        ctrl_state_e                  state;
        logic [`CTRL_STEP_W-1:0]      step;
        exc_cause_e                   cause;
        write_en_t                    raw_wen;

        instr_decoder decoder_i (
                .op        (op),
                .funct     (funct),
                .dec_class (dec_class)
        );

        ctrl_sequencer sequencer_i (
                .clk       (clk),
                .reset     (reset),
                .dec_class (dec_class),
                .flags     (flags),
                .state     (state),
                .step      (step),
                .cur_class (cur_class),
                .cause     (cause)
        );

        ctrl_outputs outputs_i (
                .clk       (clk),
                .state     (state),
                .step      (step),
                .cur_class (cur_class),
                .cause     (cause),
                .sel       (sel),
                .wen       (raw_wen)
        );

        assign wen = reset ? '0 : raw_wen;     // No writes while in reset

endmodule

`default_nettype wire

//--- verif/control_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_defs.svh"

module control_unit_tb
        import ctrl_pkg::*;
();

        localparam int N_TESTS = 116;   // All 16 classes once, then random ones
        localparam int TIMEOUT = 32;    // Longest instruction is 11 cycles

        typedef struct packed {
                int         length;
                int         n_bank;
                int         n_mem_wr;
                int         n_pc;       // pc_write outside FETCH
                int         n_epc;
                int         n_mem_reg;
                int         n_a;
                int         n_b;
                int         n_alu_out;
                logic       trap;
                logic       is_load;
                bank_reg_e  bank_reg;
                bank_data_e bank_data;
                size_e      size;
                pc_src_e    pc_src;
                iord_e      iord;
        } expect_t;

        logic                     clk;
        logic                     reset;
        logic [`CTRL_OP_W-1:0]    op;
        logic [`CTRL_FUNCT_W-1:0] funct;
        alu_flags_t               flags;
        mux_sel_t                 sel;
        write_en_t                wen;

        expect_t  exp_next;
        expect_t  exp_cur;
        string    name_next;
        string    name_cur;
        logic     in_window;
        int       cycles;
        int       n_bank;
        int       n_mem_wr;
        int       n_pc;
        int       n_epc;
        int       n_mem_reg;
        int       n_a;
        int       n_b;
        int       n_alu_out;
        mux_sel_t bank_sel, store_sel, pc_sel;
        int       windows_done;
        int       value_errors;
        int       timeout_errors;

        control_unit dut_i (
                .clk   (clk),
                .reset (reset),
                .op    (op),
                .funct (funct),
                .flags (flags),
                .sel   (sel),
                .wen   (wen)
        );

        always #20 clk = ~clk;

        function automatic size_e size_of(instr_class_e c);
                case (c)
                        LB, SB:  return SZ_BYTE;
                        LH, SH:  return SZ_HALF;
                        default: return SZ_WORD;
                endcase
        endfunction

        // Expected length, pulse counts and selects of one instruction
        function automatic expect_t expected(instr_class_e c, alu_flags_t f);
                expect_t e;
                logic    taken;
                e = '0;
                taken = 1'b0;
                e.size = size_of(c);
                e.n_a       = 1;
                e.n_b       = 1;
                e.n_alu_out = 4;        // Three fetch steps and the branch target
                case (c)
                        ADD, SUB, AND: begin
                                e.trap      = (c != AND) && f.overflow;
                                e.iord      = IORD_VEC_OVF;
                                e.length    = e.trap ? 11 : 8;
                                e.n_bank    = e.trap ? 0 : 1;
                                e.n_alu_out = 5;
                                e.bank_reg  = REG_RD;
                                e.bank_data = DATA_ALU_OUT;
                        end
                        BEQ, BNE, BGT, BLE: begin
                                case (c)
                                        BEQ:     taken = f.eq;
                                        BNE:     taken = !f.eq;
                                        BGT:     taken = f.gt;
                                        default: taken = !f.gt;
                                endcase
                                e.length = taken ? 8 : 7;
                                e.n_pc   = taken ? 1 : 0;
                                e.pc_src = PC_ALU_OUT;
                        end
                        LB, LH, LW: begin
                                e.length    = 11;
                                e.n_bank    = 1;
                                e.n_mem_reg = 1;
                                e.n_alu_out = 5;
                                e.is_load   = 1'b1;
                                e.bank_reg  = REG_RT;
                                e.bank_data = DATA_MEM;
                        end
                        SB, SH, SW: begin
                                e.length    = 11;
                                e.n_mem_wr  = 1;
                                e.n_mem_reg = 1;
                                e.n_alu_out = 5;
                        end
                        J, JAL: begin
                                e.length    = 7;
                                e.n_pc      = 1;
                                e.pc_src    = PC_JUMP;
                                e.n_bank    = (c == JAL) ? 1 : 0;
                                e.bank_reg  = REG_LINK;
                                e.bank_data = DATA_PC;
                        end
                        default: begin
                                e.trap   = 1'b1;
                                e.iord   = IORD_VEC_OP;
                                e.length = 10;
                        end
                endcase
                if (e.trap) begin
                        e.n_epc     = 3;
                        e.n_mem_reg = 3;
                        e.n_pc      = 1;
                        e.pc_src    = PC_LOAD;
                end
                return e;
        endfunction

        function automatic logic [11:0] encode(instr_class_e c);
                logic [5:0] any;
                any = 6'($urandom);     // funct is don't-care outside R-type
                case (c)
                        ADD: return {`CTRL_OP_RTYPE, `CTRL_FUNCT_ADD};
                        SUB: return {`CTRL_OP_RTYPE, `CTRL_FUNCT_SUB};
                        AND: return {`CTRL_OP_RTYPE, `CTRL_FUNCT_AND};
                        BEQ: return {`CTRL_OP_BEQ, any};
                        BNE: return {`CTRL_OP_BNE, any};
                        BGT: return {`CTRL_OP_BGT, any};
                        BLE: return {`CTRL_OP_BLE, any};
                        LB:  return {`CTRL_OP_LB, any};
                        LH:  return {`CTRL_OP_LH, any};
                        LW:  return {`CTRL_OP_LW, any};
                        SB:  return {`CTRL_OP_SB, any};
                        SH:  return {`CTRL_OP_SH, any};
                        SW:  return {`CTRL_OP_SW, any};
                        J:   return {`CTRL_OP_J, any};
                        JAL: return {`CTRL_OP_JAL, any};
                        default: begin
                                // Dropped codes: or, slt, addi, lui
                                case ($urandom_range(3))
                                        0:       return {`CTRL_OP_RTYPE, 6'h25};
                                        1:       return {`CTRL_OP_RTYPE, 6'h2a};
                                        2:       return {6'h08, any};
                                        default: return {6'h0f, any};
                                endcase
                        end
                endcase
        endfunction

        task automatic check_value(string what, int expv, int actv);
                assert (expv == actv) else begin
                        value_errors++;
                        $display("[FAIL] %s: %s expected %0d, actual %0d",
                                 name_cur, what, expv, actv);
                end
        endtask

        task automatic finish_run();
                $display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
                if (value_errors == 0 && timeout_errors == 0)
                        $display("All checks passed");
                else
                        $display("Checks failed");
                $finish;
        endtask

        task automatic clear_window();
                cycles    = 0;
                n_bank    = 0;
                n_mem_wr  = 0;
                n_pc      = 0;
                n_epc     = 0;
                n_mem_reg = 0;
                n_a       = 0;
                n_b       = 0;
                n_alu_out = 0;
        endtask

        task automatic compare_window();
                check_value("cycles", exp_cur.length, cycles);
                check_value("bank_write pulses", exp_cur.n_bank, n_bank);
                check_value("mem_wr pulses", exp_cur.n_mem_wr, n_mem_wr);
                check_value("pc_write pulses", exp_cur.n_pc, n_pc);
                check_value("epc_write pulses", exp_cur.n_epc, n_epc);
                check_value("mem_reg_write pulses", exp_cur.n_mem_reg, n_mem_reg);
                check_value("a_write pulses", exp_cur.n_a, n_a);
                check_value("b_write pulses", exp_cur.n_b, n_b);
                check_value("alu_out_write pulses", exp_cur.n_alu_out, n_alu_out);
                if (exp_cur.n_bank > 0 && n_bank > 0) begin
                        check_value("bank_reg", int'(exp_cur.bank_reg),
                                    int'(bank_sel.bank_reg));
                        check_value("bank_data", int'(exp_cur.bank_data),
                                    int'(bank_sel.bank_data));
                        if (exp_cur.is_load)
                                check_value("load_ctrl", int'(exp_cur.size),
                                            int'(bank_sel.load_ctrl));
                end
                if (exp_cur.n_mem_wr > 0 && n_mem_wr > 0)
                        check_value("store_ctrl", int'(exp_cur.size), int'(store_sel.store_ctrl));
                if (exp_cur.n_pc > 0 && n_pc > 0) begin
                        check_value("pc_src", int'(exp_cur.pc_src), int'(pc_sel.pc_src));
                        if (exp_cur.trap)
                                check_value("vector load_ctrl", int'(SZ_BYTE),
                                            int'(pc_sel.load_ctrl));
                end
        endtask

        // A window runs from after one ir_write pulse up to the next one
        always @(posedge clk) begin
                if (reset) begin
                        in_window = 1'b0;
                        clear_window();
                end else begin
                        cycles++;
                        if (wen.bank_write) begin
                                n_bank++;
                                bank_sel = sel;
                        end
                        if (wen.mem_wr) begin
                                n_mem_wr++;
                                store_sel = sel;
                        end
                        if (wen.pc_write && !wen.ir_write) begin
                                n_pc++;
                                pc_sel = sel;
                        end
                        if (wen.mem_reg_write)
                                n_mem_reg++;
                        if (wen.a_write)
                                n_a++;
                        if (wen.b_write)
                                n_b++;
                        if (wen.alu_out_write)
                                n_alu_out++;
                        if (wen.epc_write) begin
                                n_epc++;
                                if (in_window && exp_cur.trap)
                                        check_value("iord at epc_write", int'(exp_cur.iord),
                                                    int'(sel.iord));
                        end
                        if (wen.ir_write) begin
                                if (in_window) begin
                                        compare_window();
                                        windows_done++;
                                end
                                exp_cur   = exp_next;
                                name_cur  = name_next;
                                in_window = 1'b1;
                                clear_window();
                        end
                end
        end

        task automatic wait_ir_write(string what);
                int waited;
                waited = 0;
                @(negedge clk);
                while (!wen.ir_write && waited < TIMEOUT) begin
                        @(negedge clk);
                        waited++;
                end
                if (!wen.ir_write) begin
                        timeout_errors++;
                        $display("Timeout: no ir_write pulse within %0d cycles before %s",
                                 TIMEOUT, what);
                end
        endtask

        // Called in the ir_write cycle, so op stays put for the whole instruction
        task automatic issue(int idx, instr_class_e c);
                alu_flags_t  f;
                logic [11:0] code;
                f = alu_flags_t'(3'($urandom));
                code = encode(c);
                op = code[11:6];
                funct = code[5:0];
                flags = f;
                exp_next = expected(c, f);
                name_next = $sformatf("test %0d %s flags=%b", idx, c.name(), f);
        endtask

        initial begin
                instr_class_e cls;
                int           cyc;
                void'($urandom(52263));
                clk = 1'b0;
                reset = 1'b1;
                op = '0;
                funct = '0;
                flags = '0;
                windows_done = 0;
                value_errors = 0;
                timeout_errors = 0;
                name_cur = "reset";
                repeat (16) begin
                        @(negedge clk);
                        check_value("wen during reset", 0, int'(wen));
                end
                reset = 1'b0;
                cyc = 1;
                while (!wen.ir_write && cyc < TIMEOUT) begin
                        @(negedge clk);
                        cyc++;
                end
                if (!wen.ir_write) begin
                        timeout_errors++;
                        $display("Timeout: no ir_write pulse after reset");
                end else begin
                        check_value("first ir_write cycle", 4, cyc);
                end
                for (int idx = 0; idx < N_TESTS && timeout_errors == 0; idx++) begin
                        if (idx > 0)
                                wait_ir_write($sformatf("test %0d", idx));
                        if (timeout_errors == 0) begin
                                if (idx < 16)
                                        cls = instr_class_e'(4'(idx));
                                else
                                        cls = instr_class_e'(4'($urandom_range(15)));
                                issue(idx, cls);
                        end
                end
                if (timeout_errors == 0)
                        wait_ir_write("the end of the last test");
                cyc = 0;
                while (timeout_errors == 0 && windows_done < N_TESTS && cyc < 4) begin
                        @(negedge clk);
                        cyc++;
                end
                if (timeout_errors == 0 && windows_done < N_TESTS) begin
                        timeout_errors++;
                        $display("Timeout: only %0d of %0d instructions were compared",
                                 windows_done, N_TESTS);
                end
                finish_run();
        end

endmodule

`default_nettype wire

//--- all.f
+incdir+rtl
rtl/ctrl_pkg.sv
rtl/instr_decoder.sv
rtl/ctrl_sequencer.sv
rtl/ctrl_outputs.sv
rtl/control_unit.sv
verif/control_unit_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := control_unit_tb
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
